// ==== src/isa_pkg.sv ====
package isa_pkg;

    // ##########################################################
    // instruction formats
    // ##########################################################

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // opcode field lines up in all three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    // ##########################################################
    // opcodes
    // ##########################################################

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lwl     = 6'h22;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_lwr     = 6'h26;

    // special funct codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // regimm rt codes
    localparam logic [4:0] rt_bltzal = 5'h10;
    localparam logic [4:0] rt_bgezal = 5'h11;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

    // ##########################################################
    // register file types
    // ##########################################################

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t; // bit n enables byte n

    localparam int link_reg = 31;
    localparam int num_regs = 32;

    // one request on the shared write port
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
        byte_en_t  byte_en;
    } wr_req_t;

endpackage

// ==== src/alu_unit.sv ====
module alu_unit (
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    input  core_pkg::word_t   rs_data,
    input  core_pkg::word_t   rt_data,
    output core_pkg::wr_req_t req
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t     simm;
    word_t     zimm;
    word_t     result;
    reg_addr_t dest;
    logic      hit;

    assign simm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign zimm = {16'h0000, instr.i.imm};

    always_comb begin
        result = '0;
        dest   = instr.i.rt; // immediate forms write rt
        hit    = 1'b1;
        case (instr.r.opcode)
            op_special: begin
                dest = instr.r.rd;
                case (instr.r.funct)
                    fn_sll:  result = rt_data << instr.r.shamt;
                    fn_srl:  result = rt_data >> instr.r.shamt;
                    fn_sra:  result = word_t'($signed(rt_data) >>> instr.r.shamt);
                    fn_addu: result = rs_data + rt_data;
                    fn_subu: result = rs_data - rt_data;
                    fn_and:  result = rs_data & rt_data;
                    fn_or:   result = rs_data | rt_data;
                    fn_xor:  result = rs_data ^ rt_data;
                    fn_nor:  result = ~(rs_data | rt_data);
                    fn_slt:  result = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    fn_sltu: result = {31'b0, rs_data < rt_data};
                    default: hit = 1'b0; // jr, jalr go to the link unit
                endcase
            end
            op_addiu: result = rs_data + simm;
            op_slti:  result = {31'b0, $signed(rs_data) < $signed(simm)};
            op_sltiu: result = {31'b0, rs_data < simm};
            op_andi:  result = rs_data & zimm;
            op_ori:   result = rs_data | zimm;
            op_xori:  result = rs_data ^ zimm;
            op_lui:   result = {instr.i.imm, 16'h0000};
            default:  hit = 1'b0;
        endcase
    end

    assign req.valid   = instr_valid & hit;
    assign req.addr    = dest;
    assign req.data    = result;
    assign req.byte_en = 4'b1111;

endmodule

// ==== src/load_unit.sv ====
module load_unit (
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    input  core_pkg::word_t   rs_data,
    input  core_pkg::word_t   rt_data,
    input  core_pkg::word_t   mem_rdata,
    output core_pkg::word_t   mem_addr,
    output core_pkg::wr_req_t req
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t       simm;
    logic [1:0]  offset;
    word_t       shifted;  // addressed byte moved to bits 7:0
    logic [15:0] half;
    word_t       new_data;
    byte_en_t    be;
    logic        hit;

    assign simm     = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign mem_addr = rs_data + simm;
    assign offset   = mem_addr[1:0];
    assign shifted  = mem_rdata >> {offset, 3'b000};
    assign half     = mem_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        new_data = '0;
        be       = 4'b1111;
        hit      = 1'b1;
        case (instr.i.opcode)
            op_lb:  new_data = {{24{shifted[7]}}, shifted[7:0]};
            op_lbu: new_data = {24'h000000, shifted[7:0]};
            op_lh:  new_data = {{16{half[15]}}, half};
            op_lhu: new_data = {16'h0000, half};
            op_lw:  new_data = mem_rdata;
            op_lwl: begin
                new_data = mem_rdata << {2'd3 - offset, 3'b000}; // low bytes to the top
                be       = byte_en_t'(4'b1111 << (2'd3 - offset));
            end
            op_lwr: begin
                new_data = shifted; // upper bytes to the bottom
                be       = byte_en_t'(4'b1111 >> offset);
            end
            default: hit = 1'b0;
        endcase
    end

    assign req.valid   = instr_valid & hit;
    assign req.addr    = instr.i.rt;
    assign req.data    = new_data;
    assign req.byte_en = be; // regfile keeps old rt in the other bytes

endmodule

// ==== src/link_unit.sv ====
module link_unit (
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   rs_data,
    output core_pkg::word_t   next_pc,
    output core_pkg::wr_req_t req
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t     pc_4;
    word_t     pc_8;
    word_t     jump_target;
    word_t     branch_target;
    reg_addr_t dest;
    logic      hit;

    assign pc_4          = pc + 32'd4;
    assign pc_8          = pc + 32'd8;
    assign jump_target   = {pc_4[31:28], instr.j.target, 2'b00};
    assign branch_target = pc_4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

    always_comb begin
        next_pc = pc_4;
        dest    = reg_addr_t'(link_reg);
        hit     = 1'b0;
        case (instr.r.opcode)
            op_j:   next_pc = jump_target;
            op_jal: begin
                next_pc = jump_target;
                hit     = 1'b1;
            end
            op_special: begin
                if (instr.r.funct == fn_jr || instr.r.funct == fn_jalr) begin
                    next_pc = rs_data;
                end
                if (instr.r.funct == fn_jalr) begin
                    hit  = 1'b1;
                    dest = instr.r.rd; // jalr links to rd
                end
            end
            op_regimm: begin
                if (instr.i.rt == rt_bltzal) begin
                    hit = 1'b1;
                    if (rs_data[31]) next_pc = branch_target;
                end else if (instr.i.rt == rt_bgezal) begin
                    hit = 1'b1;
                    if (!rs_data[31]) next_pc = branch_target;
                end
            end
            default: ;
        endcase
    end

    // link is written whether or not the branch is taken
    assign req.valid   = instr_valid & hit;
    assign req.addr    = dest;
    assign req.data    = pc_8;
    assign req.byte_en = 4'b1111;

endmodule

// ==== src/write_arbiter.sv ====
module write_arbiter (
    input  core_pkg::wr_req_t alu_req,
    input  core_pkg::wr_req_t load_req,
    input  core_pkg::wr_req_t link_req,
    output core_pkg::wr_req_t wr_port
);

    // fixed order: alu, load, link
    always_comb begin
        if (alu_req.valid) begin
            wr_port = alu_req;
        end else if (load_req.valid) begin
            wr_port = load_req;
        end else if (link_req.valid) begin
            wr_port = link_req;
        end else begin
            wr_port = '0; // idle port
        end
    end

endmodule

// ==== src/regfile.sv ====
module regfile (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t rd_addr_1,
    input  core_pkg::reg_addr_t rd_addr_2,
    input  core_pkg::reg_addr_t rd_addr_3,
    output core_pkg::word_t     rd_data_1,
    output core_pkg::word_t     rd_data_2,
    output core_pkg::word_t     rd_data_3,
    input  core_pkg::wr_req_t   wr_port
);
    import core_pkg::*;

    word_t regs [num_regs];

    // ##########################################################
    // read ports
    // ##########################################################

    assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];
    assign rd_data_2 = (rd_addr_2 == '0) ? '0 : regs[rd_addr_2];
    assign rd_data_3 = (rd_addr_3 == '0) ? '0 : regs[rd_addr_3];

    // ##########################################################
    // write port
    // ##########################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_port.valid && wr_port.addr != '0) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_port.byte_en[b]) begin
                    regs[wr_port.addr][8*b +: 8] <= wr_port.data[8*b +: 8]; // per byte lane
                end
            end
        end
    end

endmodule

// ==== src/exec_top.sv ====
module exec_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  isa_pkg::instr_u     instr,
    input  core_pkg::word_t     pc,
    output core_pkg::word_t     mem_addr,
    input  core_pkg::word_t     mem_rdata,
    output core_pkg::word_t     next_pc,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t     dbg_data
);
    import core_pkg::*;

    word_t   rs_data;
    word_t   rt_data;
    wr_req_t alu_req;
    wr_req_t load_req;
    wr_req_t link_req;
    wr_req_t wr_port;

    alu_unit i_alu_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .req         (alu_req)
    );

    load_unit i_load_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .req         (load_req)
    );

    link_unit i_link_unit (
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .rs_data     (rs_data),
        .next_pc     (next_pc),
        .req         (link_req)
    );

    write_arbiter i_write_arbiter (
        .alu_req  (alu_req),
        .load_req (load_req),
        .link_req (link_req),
        .wr_port  (wr_port)
    );

    regfile i_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_1 (instr.r.rs),
        .rd_addr_2 (instr.r.rt),
        .rd_addr_3 (dbg_addr), // inspection port
        .rd_data_1 (rs_data),
        .rd_data_2 (rt_data),
        .rd_data_3 (dbg_data),
        .wr_port   (wr_port)
    );

endmodule

// ==== verification/exec_assert.sv ====
module exec_assert (
    input logic                clk,
    input logic                rst,
    input core_pkg::wr_req_t   alu_req,
    input core_pkg::wr_req_t   load_req,
    input core_pkg::wr_req_t   link_req,
    input core_pkg::wr_req_t   wr_port,
    input core_pkg::reg_addr_t dbg_addr,
    input core_pkg::word_t     dbg_data
);
    import core_pkg::*;

    logic    any_req;
    wr_req_t top_req; // highest priority valid request

    assign any_req = alu_req.valid | load_req.valid | link_req.valid;
    assign top_req = alu_req.valid ? alu_req : (load_req.valid ? load_req : link_req);

    one_unit: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_req.valid, load_req.valid, link_req.valid}))
        else $error("more than one unit requested the write port");

    grant_order: assert property (@(posedge clk) disable iff (rst)
        any_req |-> wr_port == top_req)
        else $error("write port does not carry the highest priority request");

    zero_reads_zero: assert property (@(posedge clk)
        dbg_addr == '0 |-> dbg_data == '0)
        else $error("register zero read back nonzero");

endmodule

bind exec_top exec_assert i_exec_assert (
    .clk      (clk),
    .rst      (rst),
    .alu_req  (alu_req),
    .load_req (load_req),
    .link_req (link_req),
    .wr_port  (wr_port),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
);

// ==== verification/exec_tb.sv ====
module exec_tb;
    import isa_pkg::*;
    import core_pkg::*;

    // reset, reg dump, alu, load, link, zero, mixed, final dump, margin
    localparam int max_cycles = 2 + 32 + 300 + 200 + 60 + 20 + 400 + 32 + 100;

    localparam logic [5:0] r_functs [11] = '{fn_sll, fn_srl, fn_sra, fn_addu, fn_subu, fn_and,
                                             fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    localparam logic [5:0] i_ops [7] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori,
                                         op_lui};
    localparam logic [5:0] ld_ops [7] = '{op_lb, op_lh, op_lwl, op_lw, op_lbu, op_lhu, op_lwr};

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_u    instr;
    word_t     pc;
    word_t     mem_addr;
    word_t     mem_rdata;
    word_t     next_pc;
    reg_addr_t dbg_addr;
    word_t     dbg_data;

    word_t       model [num_regs]; // expected register contents
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_errors;
    int          cycles = 0;

    exec_top i_exec_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .next_pc     (next_pc),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    // ##########################################################
    // random numbers and instruction generators
    // ##########################################################

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic instr_u gen_alu();
        instr_u ins;
        int     sel;
        ins = rand_bits(32);
        sel = int'(rand_bits(5) % 32'd18);
        if (sel < 11) begin
            ins.r.opcode = op_special;
            ins.r.funct  = r_functs[sel];
        end else begin
            ins.i.opcode = i_ops[sel - 11];
        end
        return ins;
    endfunction

    function automatic instr_u gen_load();
        instr_u ins;
        ins          = rand_bits(32);
        ins.i.opcode = ld_ops[int'(rand_bits(3) % 32'd7)];
        return ins;
    endfunction

    function automatic instr_u gen_link();
        instr_u ins;
        ins = rand_bits(32);
        case (rand_bits(3) % 32'd6)
            0: ins.j.opcode = op_j;
            1: ins.j.opcode = op_jal;
            2, 3: begin
                ins.r.opcode = op_special;
                ins.r.funct  = ins.r.funct[0] ? fn_jalr : fn_jr;
            end
            default: begin
                ins.i.opcode = op_regimm;
                ins.i.rt     = ins.i.rt[0] ? rt_bgezal : rt_bltzal;
            end
        endcase
        return ins;
    endfunction

    // ##########################################################
    // reference model
    // ##########################################################

    function automatic word_t alu_result(instr_u ins, word_t a, word_t b);
        word_t simm;
        word_t zimm;
        simm = {{16{ins.i.imm[15]}}, ins.i.imm};
        zimm = {16'h0000, ins.i.imm};
        if (ins.r.opcode == op_special) begin
            case (ins.r.funct)
                fn_sll:  return b << ins.r.shamt;
                fn_srl:  return b >> ins.r.shamt;
                fn_sra:  return (b >> ins.r.shamt) | (b[31] ? ~(32'hffff_ffff >> ins.r.shamt) : 0);
                fn_addu: return a + b;
                fn_subu: return a - b;
                fn_and:  return a & b;
                fn_or:   return a | b;
                fn_xor:  return a ^ b;
                fn_nor:  return ~(a | b);
                fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: return (a < b) ? 32'd1 : 32'd0; // sltu
            endcase
        end
        case (ins.i.opcode)
            op_addiu: return a + simm;
            op_slti:  return ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            op_sltiu: return (a < simm) ? 32'd1 : 32'd0;
            op_andi:  return a & zimm;
            op_ori:   return a | zimm;
            op_xori:  return a ^ zimm;
            default:  return {ins.i.imm, 16'h0000}; // lui
        endcase
    endfunction

    function automatic word_t load_result(logic [5:0] op, logic [1:0] off, word_t mem,
                                          word_t old);
        logic [7:0]  by;
        logic [15:0] hw;
        word_t       res;
        int          o;
        int          k;
        o   = int'(off);
        by  = mem[8*o +: 8];
        hw  = mem[16*(o/2) +: 16];
        res = old; // lwl and lwr keep the other bytes
        case (op)
            op_lb:  res = {{24{by[7]}}, by};
            op_lbu: res = {24'h000000, by};
            op_lh:  res = {{16{hw[15]}}, hw};
            op_lhu: res = {16'h0000, hw};
            op_lw:  res = mem;
            op_lwl: begin
                for (k = 0; k <= o; k++) res[8*(3-o+k) +: 8] = mem[8*k +: 8];
            end
            default: begin
                for (k = o; k < 4; k++) res[8*(k-o) +: 8] = mem[8*k +: 8]; // lwr
            end
        endcase
        return res;
    endfunction

    // ##########################################################
    // drive, check, report
    // ##########################################################

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("[ERROR] %s got %08h expected %08h", name, got, exp);
        errors++;
    endtask

    task automatic check_reg(input reg_addr_t a);
        instr_valid = 1'b0;
        dbg_addr    = a;
        #10;
        assert (dbg_data === model[a]) else report_mismatch("dbg_data", dbg_data, model[a]);
        checks++;
        @(negedge clk);
    endtask

    // called at a falling edge, returns at the next one
    task automatic run_instr(input instr_u ins, input word_t pc_v, input logic valid);
        word_t     rs_v;
        word_t     simm;
        word_t     mem;
        word_t     addr;
        word_t     npc;
        word_t     val;
        reg_addr_t dest;
        logic      wr;
        logic      ld;
        rs_v = model[ins.r.rs];
        simm = {{16{ins.i.imm[15]}}, ins.i.imm};
        mem  = rand_bits(32);
        addr = rs_v + simm;
        npc  = pc_v + 32'd4;
        wr   = 1'b1;
        ld   = 1'b0;
        dest = ins.i.rt;
        val  = pc_v + 32'd8; // link value
        case (ins.r.opcode)
            op_special: begin
                dest = ins.r.rd;
                if (ins.r.funct == fn_jr || ins.r.funct == fn_jalr) begin
                    npc = rs_v;
                end else begin
                    val = alu_result(ins, rs_v, model[ins.r.rt]);
                end
                wr = (ins.r.funct != fn_jr);
            end
            op_j, op_jal: begin
                npc  = {npc[31:28], ins.j.target, 2'b00};
                dest = reg_addr_t'(link_reg);
                wr   = (ins.j.opcode == op_jal);
            end
            op_regimm: begin
                dest = reg_addr_t'(link_reg);
                // bltzal wants a set sign bit, bgezal a clear one
                if (rs_v[31] == (ins.i.rt == rt_bltzal)) npc = npc + (simm << 2);
            end
            op_lb, op_lh, op_lwl, op_lw, op_lbu, op_lhu, op_lwr: begin
                ld  = 1'b1;
                val = load_result(ins.i.opcode, addr[1:0], mem, model[ins.i.rt]);
            end
            default: val = alu_result(ins, rs_v, model[ins.i.rt]);
        endcase
        instr       = ins;
        pc          = pc_v;
        mem_rdata   = mem;
        instr_valid = valid;
        dbg_addr    = dest;
        #10;
        assert (next_pc === npc) else report_mismatch("next_pc", next_pc, npc);
        if (ld) begin
            assert (mem_addr === addr) else report_mismatch("mem_addr", mem_addr, addr);
        end
        @(negedge clk);
        if (valid && wr && dest != '0) model[dest] = val;
        assert (dbg_data === model[dest]) else report_mismatch("dbg_data", dbg_data, model[dest]);
        checks++;
    endtask

    task automatic end_test(input string name);
        $display("[done] %s, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ##########################################################
    // test sequence
    // ##########################################################

    initial begin
        instr_u ins;
        int     n;
        int     sel;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        mem_rdata   = '0;
        dbg_addr    = '0;
        lfsr        = 32'h17d5_52fc;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        for (n = 0; n < num_regs; n++) model[n] = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (n = 0; n < num_regs; n++) check_reg(reg_addr_t'(n));
        end_test("registers after reset");

        for (n = 0; n < 300; n++) run_instr(gen_alu(), rand_bits(32), 1'b1);
        end_test("alu instructions");

        for (n = 0; n < 200; n++) run_instr(gen_load(), rand_bits(32), 1'b1);
        end_test("loads");

        for (n = 0; n < 60; n++) run_instr(gen_link(), rand_bits(32), 1'b1);
        end_test("jumps and links");

        for (n = 0; n < 20; n++) begin
            ins      = n[0] ? gen_load() : gen_alu();
            ins.r.rt = '0;
            ins.r.rd = '0;
            run_instr(ins, rand_bits(32), 1'b1);
        end
        end_test("register zero");

        for (n = 0; n < 400; n++) begin
            sel = int'(rand_bits(2));
            if (sel == 1) ins = gen_load();
            else if (sel == 2) ins = gen_link();
            else ins = gen_alu();
            run_instr(ins, rand_bits(32), rand_bits(2) != 32'd0); // about one in four idle
        end
        for (n = 0; n < num_regs; n++) check_reg(reg_addr_t'(n));
        end_test("mixed stream");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/isa_pkg.sv
src/core_pkg.sv
src/alu_unit.sv
src/load_unit.sv
src/link_unit.sv
src/write_arbiter.sv
src/regfile.sv
src/exec_top.sv
verification/exec_assert.sv
verification/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module exec_tb -f list.f -o exec_sim \
    && ./obj_dir/exec_sim | tee /dev/stderr | grep -qx "test passed" \
    || { echo "simulation did not pass"; exit 1; }
